// File: common/decode_pkg.sv
package decode_pkg;

    localparam int inst_width = 32;
    localparam int imm_width = 20;         // Widest immediate is the lui/auipc upper field
    localparam int reg_width = 5;
    localparam int csr_id_width = 12;
    localparam int queue_depth = 4;        // Power of two so pointers wrap freely
    localparam int queue_ptr_width = $clog2(queue_depth);

    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b010,
        br_bge  = 3'b011,
        br_jal  = 3'b100,
        br_jalr = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_op_e;

    typedef enum logic [3:0] {
        mem_lb  = 4'b0000,
        mem_lh  = 4'b0001,
        mem_lw  = 4'b0010,
        mem_lbu = 4'b0100,
        mem_lhu = 4'b0101,
        mem_sb  = 4'b1000,
        mem_sh  = 4'b1100,
        mem_sw  = 4'b1010
    } mem_op_e;

    typedef enum logic [4:0] {
        int_add   = 5'b00000,
        int_sub   = 5'b01101,
        int_sll   = 5'b01000,
        int_slt   = 5'b00010,
        int_sltu  = 5'b10010,
        int_xor   = 5'b00100,
        int_srl   = 5'b01001,
        int_sra   = 5'b11001,
        int_or    = 5'b00110,
        int_and   = 5'b00101,
        int_lui   = 5'b00001,
        int_auipc = 5'b01100,
        int_nop   = 5'b00011          // Fence lands here
    } int_op_e;

    typedef enum logic [2:0] {
        csr_none   = 3'b000,
        csr_rw     = 3'b001,
        csr_rs     = 3'b010,
        csr_rc     = 3'b011,
        csr_rwi    = 3'b101,
        csr_rsi    = 3'b110,
        csr_rci    = 3'b111
    } csr_op_e;

    // Trap causes follow mcause where one exists
    typedef enum logic [3:0] {
        exc_iam  = 4'd0,
        exc_ii   = 4'd2,
        exc_bp   = 4'd3,
        exc_ec   = 4'd8,
        exc_mret = 4'd10,
        exc_sret = 4'd11,
        exc_ipf  = 4'd12,
        exc_none = 4'd15
    } exc_code_e;

    typedef enum logic [1:0] {
        class_int    = 2'd0,
        class_branch = 2'd1,
        class_mem    = 2'd2,
        class_csr    = 2'd3
    } issue_class_e;

endpackage

// File: decode/decode_unit.sv
module decode_unit (
    input  logic [decode_pkg::inst_width-1:0]   inst,
    input  logic                                iam,
    input  logic                                ipf,
    output logic                                intv,
    output logic                                branchv,
    output logic                                memv,
    output logic                                csrv,
    output decode_pkg::int_op_e                 int_op,
    output decode_pkg::branch_op_e              branch_op,
    output decode_pkg::mem_op_e                 mem_op,
    output decode_pkg::csr_op_e                 csr_op,
    output decode_pkg::exc_code_e               exc_code,
    output logic [decode_pkg::reg_width-1:0]    rs1,
    output logic [decode_pkg::reg_width-1:0]    rs2,
    output logic [decode_pkg::reg_width-1:0]    rd,
    output logic                                we,
    output logic [decode_pkg::imm_width-1:0]    imm,
    output logic                                immv,
    output logic                                uext,
    output logic [decode_pkg::csr_id_width-1:0] csr_id
);
    import decode_pkg::*;

    logic [4:0] op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [7:0] f3;
    logic f7_0, f7_5;
    logic op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store;
    logic op_miscmem, op_imm, op_reg, op_system;
    logic beq, bne, blt, bge, bltu, bgeu, br_cond, jal, jalr;
    logic lb, lh, lw, lbu, lhu, sb, sh, sw, load_any, store_any;
    logic alu_any, fence;
    logic sel_add, sel_sub, sel_sll, sel_slt, sel_sltu, sel_xor, sel_srl, sel_sra;
    logic sel_or, sel_and;
    logic ecall, ebreak, mret, sret, sys_trap;
    logic csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci, csr_any;
    logic legal, illegal, exc_any;
    logic [imm_width-1:0] b_imm, j_imm, u_imm, i_imm, s_imm, z_imm;

    assign op = inst[6:2];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign f3 = 8'b1 << funct3;            // One-hot funct3
    assign f7_0 = (funct7 == 7'h00);
    assign f7_5 = (funct7 == 7'h20);

    assign op_lui = (op == 5'b01101);
    assign op_auipc = (op == 5'b00101);
    assign op_jal = (op == 5'b11011);
    assign op_jalr = (op == 5'b11001);
    assign op_branch = (op == 5'b11000);
    assign op_load = (op == 5'b00000);
    assign op_store = (op == 5'b01000);
    assign op_miscmem = (op == 5'b00011);
    assign op_imm = (op == 5'b00100);
    assign op_reg = (op == 5'b01100);
    assign op_system = (op == 5'b11100);

    assign beq = op_branch & f3[0];
    assign bne = op_branch & f3[1];
    assign blt = op_branch & f3[4];
    assign bge = op_branch & f3[5];
    assign bltu = op_branch & f3[6];
    assign bgeu = op_branch & f3[7];
    assign br_cond = beq | bne | blt | bge | bltu | bgeu;
    assign jal = op_jal;
    assign jalr = op_jalr & f3[0];

    assign lb = op_load & f3[0];
    assign lh = op_load & f3[1];
    assign lw = op_load & f3[2];
    assign lbu = op_load & f3[4];
    assign lhu = op_load & f3[5];
    assign sb = op_store & f3[0];
    assign sh = op_store & f3[1];
    assign sw = op_store & f3[2];
    assign load_any = lb | lh | lw | lbu | lhu;
    assign store_any = sb | sh | sw;

    // Immediate and register forms share one term per operation
    assign sel_add = (op_imm | (op_reg & f7_0)) & f3[0];
    assign sel_sub = op_reg & f7_5 & f3[0];
    assign sel_sll = (op_imm | op_reg) & f7_0 & f3[1];
    assign sel_slt = (op_imm | (op_reg & f7_0)) & f3[2];
    assign sel_sltu = (op_imm | (op_reg & f7_0)) & f3[3];
    assign sel_xor = (op_imm | (op_reg & f7_0)) & f3[4];
    assign sel_srl = (op_imm | op_reg) & f7_0 & f3[5];
    assign sel_sra = (op_imm | op_reg) & f7_5 & f3[5];
    assign sel_or = (op_imm | (op_reg & f7_0)) & f3[6];
    assign sel_and = (op_imm | (op_reg & f7_0)) & f3[7];
    assign alu_any = sel_add | sel_sub | sel_sll | sel_slt | sel_sltu | sel_xor
                   | sel_srl | sel_sra | sel_or | sel_and;
    assign fence = op_miscmem & f3[0];     // Issues as an int nop without any ordering

    assign ecall = op_system & f3[0] & f7_0 & (inst[24:20] == 5'd0);
    assign ebreak = op_system & f3[0] & f7_0 & (inst[24:20] == 5'd1);
    assign mret = op_system & f3[0] & (funct7 == 7'h18) & (inst[24:20] == 5'd2);
    assign sret = op_system & f3[0] & (funct7 == 7'h08) & (inst[24:20] == 5'd2);
    assign sys_trap = ecall | ebreak | mret | sret;

    assign csrrw = op_system & f3[1];
    assign csrrs = op_system & f3[2];
    assign csrrc = op_system & f3[3];
    assign csrrwi = op_system & f3[5];
    assign csrrsi = op_system & f3[6];
    assign csrrci = op_system & f3[7];
    assign csr_any = csrrw | csrrs | csrrc | csrrwi | csrrsi | csrrci;

    assign legal = (inst[1:0] == 2'b11)
                 & (br_cond | jal | jalr | load_any | store_any | op_lui | op_auipc
                    | alu_any | fence | csr_any | sys_trap);
    assign illegal = ~legal;
    assign exc_any = illegal | ipf | iam | sys_trap;

    // Faulted words only ever go to the CSR path
    assign intv = (op_lui | op_auipc | alu_any | fence) & ~exc_any;
    assign branchv = (br_cond | jal | jalr) & ~exc_any;
    assign memv = (load_any | store_any) & ~exc_any;
    assign csrv = csr_any | exc_any;

    assign int_op = int_op_e'({sel_sltu | sel_sra,
                               sel_sll | sel_srl | sel_sra | op_auipc | sel_sub,
                               sel_xor | sel_or | sel_and | op_auipc | sel_sub,
                               sel_slt | sel_sltu | sel_or | fence,
                               op_lui | sel_and | sel_srl | sel_sra | fence | sel_sub});
    assign branch_op = branch_op_e'({jal | jalr | bltu | bgeu,
                                     blt | bge | bltu | bgeu,
                                     jalr | bne | bge | bgeu});
    assign mem_op = mem_op_e'({store_any, sh | lbu | lhu, lw | sw, lh | lhu});
    assign csr_op = csr_op_e'({csrrwi | csrrsi | csrrci,
                               csrrs | csrrc | csrrsi | csrrci,
                               csrrw | csrrc | csrrwi | csrrci});

    assign exc_code = illegal ? exc_ii :
                      ipf     ? exc_ipf :
                      iam     ? exc_iam :
                      ecall   ? exc_ec :
                      ebreak  ? exc_bp :
                      mret    ? exc_mret :
                      sret    ? exc_sret : exc_none;

    assign rs1 = {reg_width{jalr | op_branch | op_load | op_store | op_imm | op_reg
                            | csrrw | csrrs | csrrc}} & inst[19:15];
    assign rs2 = {reg_width{op_branch | op_store | op_reg}} & inst[24:20];
    assign rd = {reg_width{op_lui | op_auipc | jal | jalr | op_load | op_imm | op_reg
                           | csr_any}} & inst[11:7];
    assign we = (rd != '0);

    assign b_imm = {7'b0, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign j_imm = {inst[31], inst[19:12], inst[20], inst[30:21]};  // Offset in halfwords
    assign u_imm = inst[31:12];
    assign i_imm = {8'b0, inst[31:20]};
    assign s_imm = {8'b0, inst[31:25], inst[11:7]};
    assign z_imm = {15'b0, inst[19:15]};    // CSR zimm

    assign imm = ({imm_width{br_cond}} & b_imm)
               | ({imm_width{jal}} & j_imm)
               | ({imm_width{op_lui | op_auipc}} & u_imm)
               | ({imm_width{load_any | op_imm | fence | jalr}} & i_imm)
               | ({imm_width{store_any}} & s_imm)
               | ({imm_width{csr_any}} & z_imm);
    assign immv = op_imm & alu_any;
    assign uext = sel_sltu | lbu | lhu | bltu | bgeu | sel_srl;
    assign csr_id = inst[31:20];

endmodule

// File: logic/inst_queue.sv
module inst_queue (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              push,
    input  logic [decode_pkg::inst_width-1:0] in_inst,
    input  logic                              in_iam,
    input  logic                              in_ipf,
    input  logic                              pop,
    output logic [decode_pkg::inst_width-1:0] head_inst,
    output logic                              head_iam,
    output logic                              head_ipf,
    output logic                              empty,
    output logic                              full
);
    import decode_pkg::*;

    logic [inst_width-1:0] inst_mem [queue_depth];
    logic iam_mem [queue_depth];
    logic ipf_mem [queue_depth];
    logic [queue_ptr_width-1:0] wr_ptr;
    logic [queue_ptr_width-1:0] rd_ptr;
    logic [queue_ptr_width:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push & ~full;         // Word is lost if producer ignores full
    assign do_pop = pop & ~empty;
    assign empty = (count == '0);
    assign full = (count == (queue_ptr_width + 1)'(queue_depth));

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= in_inst;
            iam_mem[wr_ptr] <= in_iam;
            ipf_mem[wr_ptr] <= in_ipf;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    assign head_inst = inst_mem[rd_ptr];
    assign head_iam = iam_mem[rd_ptr];
    assign head_ipf = ipf_mem[rd_ptr];

    // Producer must watch full
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("inst_queue: push while full, word dropped");

    // Dispatch must only pop a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("inst_queue: pop while empty");

endmodule

// File: logic/dispatch_reg.sv
module dispatch_reg (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stall,
    input  logic                                empty,
    input  logic                                intv,
    input  logic                                branchv,
    input  logic                                memv,
    input  logic                                csrv,
    input  decode_pkg::int_op_e                 dec_int_op,
    input  decode_pkg::branch_op_e              dec_branch_op,
    input  decode_pkg::mem_op_e                 dec_mem_op,
    input  decode_pkg::csr_op_e                 dec_csr_op,
    input  decode_pkg::exc_code_e               dec_exc_code,
    input  logic [decode_pkg::reg_width-1:0]    dec_rs1,
    input  logic [decode_pkg::reg_width-1:0]    dec_rs2,
    input  logic [decode_pkg::reg_width-1:0]    dec_rd,
    input  logic                                dec_we,
    input  logic [decode_pkg::imm_width-1:0]    dec_imm,
    input  logic                                dec_immv,
    input  logic                                dec_uext,
    input  logic [decode_pkg::csr_id_width-1:0] dec_csr_id,
    output logic                                pop,
    output logic                                issue_valid,
    output decode_pkg::issue_class_e            issue_class,
    output decode_pkg::int_op_e                 int_op,
    output decode_pkg::branch_op_e              branch_op,
    output decode_pkg::mem_op_e                 mem_op,
    output decode_pkg::csr_op_e                 csr_op,
    output decode_pkg::exc_code_e               exc_code,
    output logic [decode_pkg::reg_width-1:0]    rs1,
    output logic [decode_pkg::reg_width-1:0]    rs2,
    output logic [decode_pkg::reg_width-1:0]    rd,
    output logic                                we,
    output logic [decode_pkg::imm_width-1:0]    imm,
    output logic                                immv,
    output logic                                uext,
    output logic [decode_pkg::csr_id_width-1:0] csr_id
);
    import decode_pkg::*;

    issue_class_e next_class;

    // CSR first so trapping words never reach another unit
    always_comb begin
        if (csrv)
            next_class = class_csr;
        else if (memv)
            next_class = class_mem;
        else if (branchv)
            next_class = class_branch;
        else
            next_class = class_int;
    end

    assign pop = ~empty & ~stall;

    always_ff @(posedge clk) begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_class <= next_class;
            int_op <= dec_int_op;
            branch_op <= dec_branch_op;
            mem_op <= dec_mem_op;
            csr_op <= dec_csr_op;
            exc_code <= dec_exc_code;
            rs1 <= dec_rs1;
            rs2 <= dec_rs2;
            rd <= dec_rd;
            we <= dec_we;
            imm <= dec_imm;
            immv <= dec_immv;
            uext <= dec_uext;
            csr_id <= dec_csr_id;
        end
    end

    // Decoder must hand over exactly one class per popped word
    a_one_class: assert property (@(posedge clk) disable iff (reset)
        pop |-> $onehot({intv, branchv, memv, csrv}))
        else $error("dispatch_reg: class valids not one-hot on pop");

endmodule

// File: logic/decode_stage.sv
module decode_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                inst_valid,
    input  logic [decode_pkg::inst_width-1:0]   inst,
    input  logic                                iam,
    input  logic                                ipf,
    input  logic                                stall,
    output logic                                full,
    output logic                                issue_valid,
    output decode_pkg::issue_class_e            issue_class,
    output decode_pkg::int_op_e                 int_op,
    output decode_pkg::branch_op_e              branch_op,
    output decode_pkg::mem_op_e                 mem_op,
    output decode_pkg::csr_op_e                 csr_op,
    output decode_pkg::exc_code_e               exc_code,
    output logic [decode_pkg::reg_width-1:0]    rs1,
    output logic [decode_pkg::reg_width-1:0]    rs2,
    output logic [decode_pkg::reg_width-1:0]    rd,
    output logic                                we,
    output logic [decode_pkg::imm_width-1:0]    imm,
    output logic                                uext,
    output logic                                immv,
    output logic [decode_pkg::csr_id_width-1:0] csr_id
);
    import decode_pkg::*;

    logic [inst_width-1:0] head_inst;
    logic head_iam, head_ipf;
    logic empty, pop;
    logic intv, branchv, memv, csrv;
    int_op_e dec_int_op;
    branch_op_e dec_branch_op;
    mem_op_e dec_mem_op;
    csr_op_e dec_csr_op;
    exc_code_e dec_exc_code;
    logic [reg_width-1:0] dec_rs1, dec_rs2, dec_rd;
    logic dec_we, dec_immv, dec_uext;
    logic [imm_width-1:0] dec_imm;
    logic [csr_id_width-1:0] dec_csr_id;

    inst_queue u_queue (
        .clk(clk), .reset(reset),
        .push(inst_valid), .in_inst(inst), .in_iam(iam), .in_ipf(ipf),
        .pop(pop),
        .head_inst(head_inst), .head_iam(head_iam), .head_ipf(head_ipf),
        .empty(empty), .full(full)
    );

    decode_unit u_decode (
        .inst(head_inst), .iam(head_iam), .ipf(head_ipf),
        .intv(intv), .branchv(branchv), .memv(memv), .csrv(csrv),
        .int_op(dec_int_op), .branch_op(dec_branch_op), .mem_op(dec_mem_op),
        .csr_op(dec_csr_op), .exc_code(dec_exc_code),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .we(dec_we),
        .imm(dec_imm), .immv(dec_immv), .uext(dec_uext), .csr_id(dec_csr_id)
    );

    dispatch_reg u_dispatch (
        .clk(clk), .reset(reset), .stall(stall), .empty(empty),
        .intv(intv), .branchv(branchv), .memv(memv), .csrv(csrv),
        .dec_int_op(dec_int_op), .dec_branch_op(dec_branch_op),
        .dec_mem_op(dec_mem_op), .dec_csr_op(dec_csr_op), .dec_exc_code(dec_exc_code),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd(dec_rd), .dec_we(dec_we),
        .dec_imm(dec_imm), .dec_immv(dec_immv), .dec_uext(dec_uext),
        .dec_csr_id(dec_csr_id),
        .pop(pop), .issue_valid(issue_valid), .issue_class(issue_class),
        .int_op(int_op), .branch_op(branch_op), .mem_op(mem_op), .csr_op(csr_op),
        .exc_code(exc_code), .rs1(rs1), .rs2(rs2), .rd(rd), .we(we),
        .imm(imm), .immv(immv), .uext(uext), .csr_id(csr_id)
    );

endmodule

// File: bench/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected decode of one word where sub_op follows the natural class
typedef struct packed {
    logic         legal;
    issue_class_e cls;
    issue_class_e nat_cls;
    logic [4:0]   sub_op;
    exc_code_e    exc;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [4:0]   rd;
    logic         we;
    logic [19:0]  imm;
    logic         immv;
    logic         uext;
    logic [11:0]  csr_id;
} exp_t;

function automatic exp_t decode_ref(input logic [31:0] w, input logic f_iam, input logic f_ipf);
    exp_t e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [20:0] j_off;
    logic [12:0] b_off;
    logic use_rs1, use_rs2, use_rd, base_ok;
    opc = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    e = '0;
    e.legal = 1'b1;
    e.nat_cls = class_int;
    e.exc = exc_none;
    e.csr_id = w[31:20];
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd = 1'b0;
    base_ok = !opc[5] || f7 == 7'h00;      // Register forms need funct7 zero
    case (opc)
        7'b0110111, 7'b0010111: begin
            e.sub_op = opc[5] ? 5'(int_lui) : 5'(int_auipc);
            use_rd = 1'b1;
            e.imm = w[31:12];
        end
        7'b1101111: begin
            e.nat_cls = class_branch;
            e.sub_op = 5'(br_jal);
            use_rd = 1'b1;
            e.imm = j_off[20:1];                // Halfword offset
        end
        7'b1100111: begin
            e.nat_cls = class_branch;
            e.sub_op = 5'(br_jalr);
            e.legal = (f3 == 3'd0);
            use_rs1 = 1'b1;
            use_rd = 1'b1;
            e.imm = {8'b0, w[31:20]};
        end
        7'b1100011: begin
            e.nat_cls = class_branch;
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            e.imm = {7'b0, b_off};
            e.uext = (f3 == 3'd6) || (f3 == 3'd7);
            case (f3)
                3'd0: e.sub_op = 5'(br_beq);
                3'd1: e.sub_op = 5'(br_bne);
                3'd4: e.sub_op = 5'(br_blt);
                3'd5: e.sub_op = 5'(br_bge);
                3'd6: e.sub_op = 5'(br_bltu);
                3'd7: e.sub_op = 5'(br_bgeu);
                default: e.legal = 1'b0;
            endcase
        end
        7'b0000011: begin
            e.nat_cls = class_mem;
            use_rs1 = 1'b1;
            use_rd = 1'b1;
            e.imm = {8'b0, w[31:20]};
            e.uext = (f3 == 3'd4) || (f3 == 3'd5);
            case (f3)
                3'd0: e.sub_op = 5'(mem_lb);
                3'd1: e.sub_op = 5'(mem_lh);
                3'd2: e.sub_op = 5'(mem_lw);
                3'd4: e.sub_op = 5'(mem_lbu);
                3'd5: e.sub_op = 5'(mem_lhu);
                default: e.legal = 1'b0;
            endcase
        end
        7'b0100011: begin
            e.nat_cls = class_mem;
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            e.imm = {8'b0, w[31:25], w[11:7]};
            case (f3)
                3'd0: e.sub_op = 5'(mem_sb);
                3'd1: e.sub_op = 5'(mem_sh);
                3'd2: e.sub_op = 5'(mem_sw);
                default: e.legal = 1'b0;
            endcase
        end
        7'b0001111: begin
            e.sub_op = 5'(int_nop);             // Fence
            e.legal = (f3 == 3'd0);
            e.imm = {8'b0, w[31:20]};
        end
        7'b0010011, 7'b0110011: begin
            use_rs1 = 1'b1;
            use_rd = 1'b1;
            use_rs2 = opc[5];
            if (!opc[5]) begin
                e.imm = {8'b0, w[31:20]};
                e.immv = 1'b1;
            end
            case (f3)
                3'd0: begin
                    if (opc[5] && f7 == 7'h20) begin
                        e.sub_op = 5'(int_sub);
                    end else begin
                        e.sub_op = 5'(int_add);
                        e.legal = base_ok;
                    end
                end
                3'd1: begin
                    e.sub_op = 5'(int_sll);
                    e.legal = (f7 == 7'h00);
                end
                3'd2: begin
                    e.sub_op = 5'(int_slt);
                    e.legal = base_ok;
                end
                3'd3: begin
                    e.sub_op = 5'(int_sltu);
                    e.uext = 1'b1;
                    e.legal = base_ok;
                end
                3'd4: begin
                    e.sub_op = 5'(int_xor);
                    e.legal = base_ok;
                end
                3'd5: begin
                    if (f7 == 7'h00) begin
                        e.sub_op = 5'(int_srl);
                        e.uext = 1'b1;
                    end else if (f7 == 7'h20) begin
                        e.sub_op = 5'(int_sra);
                    end else begin
                        e.legal = 1'b0;
                    end
                end
                3'd6: begin
                    e.sub_op = 5'(int_or);
                    e.legal = base_ok;
                end
                default: begin
                    e.sub_op = 5'(int_and);
                    e.legal = base_ok;
                end
            endcase
        end
        7'b1110011: begin
            e.nat_cls = class_csr;
            e.sub_op = 5'(csr_none);
            if (f3 == 3'd0) begin
                case (w[31:20])
                    12'h000: e.exc = exc_ec;
                    12'h001: e.exc = exc_bp;
                    12'h302: e.exc = exc_mret;
                    12'h102: e.exc = exc_sret;
                    default: e.legal = 1'b0;
                endcase
            end else if (f3 == 3'd4) begin
                e.legal = 1'b0;
            end else begin
                use_rs1 = !f3[2];               // Immediate forms carry zimm in rs1 slot
                use_rd = 1'b1;
                e.imm = {15'b0, w[19:15]};
                case (f3)
                    3'd1: e.sub_op = 5'(csr_rw);
                    3'd2: e.sub_op = 5'(csr_rs);
                    3'd3: e.sub_op = 5'(csr_rc);
                    3'd5: e.sub_op = 5'(csr_rwi);
                    3'd6: e.sub_op = 5'(csr_rsi);
                    default: e.sub_op = 5'(csr_rci);
                endcase
            end
        end
        default: e.legal = 1'b0;            // Also catches low bits other than 11
    endcase
    e.rs1 = use_rs1 ? w[19:15] : 5'd0;
    e.rs2 = use_rs2 ? w[24:20] : 5'd0;
    e.rd = use_rd ? w[11:7] : 5'd0;
    e.we = (e.rd != 5'd0);
    if (!e.legal)
        e.exc = exc_ii;
    else if (f_ipf)
        e.exc = exc_ipf;
    else if (f_iam)
        e.exc = exc_iam;
    e.cls = (e.exc != exc_none || e.nat_cls == class_csr) ? class_csr : e.nat_cls;
    return e;
endfunction

`endif

// File: bench/decode_tb.sv
module decode_tb;
    import decode_pkg::*;

    `include "decode_ref.svh"

    localparam int clk_period = 4;

    logic clk = 1'b0;
    logic reset;
    logic inst_valid;
    logic [inst_width-1:0] inst;
    logic iam;
    logic ipf;
    logic stall;
    logic full;
    logic issue_valid;
    issue_class_e issue_class;
    int_op_e int_op;
    branch_op_e branch_op;
    mem_op_e mem_op;
    csr_op_e csr_op;
    exc_code_e exc_code;
    logic [reg_width-1:0] rs1;
    logic [reg_width-1:0] rs2;
    logic [reg_width-1:0] rd;
    logic we;
    logic [imm_width-1:0] imm;
    logic uext;
    logic immv;
    logic [csr_id_width-1:0] csr_id;

    int seed;
    int n_words = 0;
    int n_issued = 0;
    int exp_count = 0;                     // Words the queue should hold
    logic stalled_last = 1'b0;
    logic [33:0] stim_q[$];                // {ipf, iam, word}
    exp_t sb_q[$];

    decode_stage dut (.*);

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [6:0] major_opcode(input int idx);
        case (idx)
            0: return 7'b0110111;
            1: return 7'b0010111;
            2: return 7'b1101111;
            3: return 7'b1100111;
            4: return 7'b1100011;
            5: return 7'b0000011;
            6: return 7'b0100011;
            7: return 7'b0001111;
            8: return 7'b0010011;
            9: return 7'b0110011;
            default: return 7'b1110011;
        endcase
    endfunction

    task automatic add_word(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                            input logic [1:0] faults);
        logic [31:0] r;
        r = $random(seed);
        stim_q.push_back({faults, f7, r[24:15], f3, r[11:7], opc});
    endtask

    task automatic build_stimulus();
        logic [31:0] r;
        logic [31:0] r2;
        for (int op_i = 0; op_i < 11; op_i++) begin
            for (int f = 0; f < 8; f++) begin
                add_word(major_opcode(op_i), 3'(f), 7'h00, 2'b00);
                add_word(major_opcode(op_i), 3'(f), 7'h20, 2'b00);
            end
        end
        stim_q.push_back({2'b00, 32'h00000073});   // ecall
        stim_q.push_back({2'b00, 32'h00100073});   // ebreak
        stim_q.push_back({2'b00, 32'h30200073});   // mret
        stim_q.push_back({2'b00, 32'h10200073});   // sret
        for (int f = 1; f < 8; f++) begin
            r = $random(seed);
            add_word(7'b1110011, 3'(f), r[6:0], 2'b00);  // Wide spread of csr_id
        end
        // Mostly legal words with random fault flags
        repeat (120) begin
            r = $random(seed);
            add_word(major_opcode(int'(r[3:0]) % 11), r[6:4], r[7] ? 7'h20 : 7'h00, r[9:8]);
        end
        repeat (80) begin
            r = $random(seed);
            r2 = $random(seed);
            stim_q.push_back({r2[1:0], r});
        end
    endtask

    task automatic drive_word(input logic [33:0] s);
        inst_valid = 1'b1;
        inst = s[31:0];
        iam = s[32];
        ipf = s[33];
        sb_q.push_back(decode_ref(s[31:0], s[32], s[33]));
    endtask

    task automatic compare_issue(input exp_t e);
        check("issue_class", 32'(issue_class), 32'(e.cls));
        check("exc_code", 32'(exc_code), 32'(e.exc));
        if (e.legal) begin
            case (e.nat_cls)
                class_int: check("int_op", 32'(int_op), 32'(e.sub_op));
                class_branch: check("branch_op", 32'(branch_op), 32'(e.sub_op));
                class_mem: check("mem_op", 32'(mem_op), 32'(e.sub_op));
                default: begin
                    check("csr_op", 32'(csr_op), 32'(e.sub_op));
                    check("csr_id", 32'(csr_id), 32'(e.csr_id));
                end
            endcase
            check("rs1", 32'(rs1), 32'(e.rs1));
            check("rs2", 32'(rs2), 32'(e.rs2));
            check("rd", 32'(rd), 32'(e.rd));
            check("we", 32'(we), 32'(e.we));
            check("imm", 32'(imm), 32'(e.imm));
            check("immv", 32'(immv), 32'(e.immv));
            check("uext", 32'(uext), 32'(e.uext));
        end
    endtask

    // Queue fills on accepted pushes and drains on every unstalled edge
    always @(posedge clk) begin
        stalled_last <= stall;
        if (reset)
            exp_count <= 0;
        else
            exp_count <= exp_count + ((inst_valid && exp_count < queue_depth) ? 1 : 0)
                         - ((exp_count > 0 && !stall) ? 1 : 0);
    end

    // Outputs settle after the rising edge and are read on the falling one
    always @(negedge clk) begin
        check("full", 32'(full), 32'(exp_count == queue_depth));
        if (stalled_last === 1'b1)
            check("issue_valid", 32'(issue_valid), 32'd0);
        if (issue_valid === 1'b1) begin
            if (sb_q.size() == 0) begin
                $display("issue_valid seen with no word outstanding");
                stop_with_failure();
            end else begin
                compare_issue(sb_q.pop_front());
                n_issued++;
            end
        end
    end

    initial begin
        int limit;
        wait (n_words != 0);
        limit = (n_words * 20 + 8) * clk_period;
        #(limit);
        $display("run timed out");
        stop_with_failure();
    end

    initial begin
        logic [31:0] r;
        seed = 32'hfab2ddf5;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        iam = 1'b0;
        ipf = 1'b0;
        stall = 1'b0;
        build_stimulus();
        n_words = stim_q.size();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check("issue_valid", 32'(issue_valid), 32'd0);
        check("full", 32'(full), 32'd0);

        // Two edges from push to issue on an empty queue
        drive_word(stim_q.pop_front());
        @(negedge clk);
        inst_valid = 1'b0;
        check("issue_valid", 32'(issue_valid), 32'd0);
        @(negedge clk);
        check("issue_valid", 32'(issue_valid), 32'd1);

        // Fill the queue behind a stall until full rises
        stall = 1'b1;
        repeat (queue_depth) begin
            drive_word(stim_q.pop_front());
            @(negedge clk);
        end
        inst_valid = 1'b0;
        check("full", 32'(full), 32'd1);

        while (stim_q.size() > 0) begin
            @(negedge clk);
            r = $random(seed);
            stall = (r[1:0] == 2'b00);
            if (!full && r[3:2] != 2'b00)
                drive_word(stim_q.pop_front());
            else
                inst_valid = 1'b0;
        end
        @(negedge clk);
        inst_valid = 1'b0;
        stall = 1'b0;
        wait (n_issued == n_words);
        repeat (4) @(negedge clk);
        if (n_issued == n_words && sb_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("issued %0d words, expected %0d", n_issued, n_words);
            stop_with_failure();
        end
    end

endmodule

// File: vlog.f
+incdir+bench
common/decode_pkg.sv
decode/decode_unit.sv
logic/inst_queue.sv
logic/dispatch_reg.sv
logic/decode_stage.sv
bench/decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=decode_tb
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module "$top" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
